// ==== project.f ====
design/seq_pkg.sv
design/seq_ifs.sv
design/call_stack.sv
design/loop_unit.sv
design/pc_sequencer.sv
design/flow_core.sv
tests/flow_core_props.sv
tests/flow_core_tb.sv

// ==== tests/flow_core_tb.sv ====
`timescale 1ns/1ps

module flow_core_tb;

  localparam int CSTACK_DEPTH = 4;
  localparam int LSTACK_DEPTH = 3;
  // The tests and their resets take roughly 360 cycles
  localparam int TIMEOUT_CYCLES = 600;

  typedef struct packed {
    seq_pkg::prog_addr_t beginning;
    seq_pkg::prog_addr_t ending;
    logic                infinite;
    seq_pkg::word_t      total;
    seq_pkg::word_t      index;
  } loop_rec_t;

  logic                clk;
  logic                rst;
  seq_pkg::prog_addr_t programmem_addr;
  seq_pkg::instr_t     programmem_read_value;
  seq_pkg::word_t      loop_index;

  seq_pkg::instr_t     mem [256];

  // The reference model keeps the top of its call and loop stacks at index 0
  seq_pkg::prog_addr_t m_pc;
  seq_pkg::prog_addr_t m_calls [$];
  loop_rec_t           m_loop;
  loop_rec_t           m_loops [$];
  seq_pkg::prog_addr_t exp_addr;
  seq_pkg::word_t      exp_index;

  logic checking;
  int   cycle_count = 0;
  int   checks;
  int   errors;
  int   tests;
  int   failed;

  flow_core #(
    .CSTACK_DEPTH(CSTACK_DEPTH),
    .LSTACK_DEPTH(LSTACK_DEPTH)
  ) u_flow_core (
    .clk                   (clk),
    .rst                   (rst),
    .programmem_addr       (programmem_addr),
    .programmem_read_value (programmem_read_value),
    .loop_index            (loop_index)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Registered program memory read
  always @(posedge clk) begin
    programmem_read_value <= mem[programmem_addr];
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles", cycle_count);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic seq_pkg::instr_t encode(logic [7:0] op, seq_pkg::word_t imm);
    return {imm, op};
  endfunction

  // NOP or an undefined opcode with a random immediate
  function automatic seq_pkg::instr_t filler_word();
    logic [7:0] op;
    if ($urandom % 2 == 0) begin
      op = seq_pkg::OP_NOP;
    end else begin
      op = 8'h09 + 8'($urandom % 247);
    end
    return encode(op, seq_pkg::word_t'($urandom));
  endfunction

  function automatic loop_rec_t reset_loop();
    loop_rec_t r;
    r = '0;
    r.infinite = 1'b1;
    return r;
  endfunction

  function automatic int total_errors();
    return errors + u_flow_core.u_props.fail_count;
  endfunction

  task automatic model_reset();
    m_pc = '0;
    m_calls.delete();
    m_loops.delete();
    m_loop = reset_loop();
  endtask

  // Retires the instruction at m_pc and returns the fetch address that follows it
  task automatic model_cycle(output seq_pkg::prog_addr_t nxt);
    seq_pkg::instr_t     ins;
    logic [7:0]          op;
    seq_pkg::word_t      imm;
    seq_pkg::prog_addr_t inc;
    logic                halt;
    logic                start;
    logic                at_end;
    logic                leave;
    ins    = mem[m_pc];
    op     = ins[7:0];
    imm    = ins[23:8];
    inc    = m_pc + 8'd1;
    halt   = (op == seq_pkg::OP_HALT);
    start  = (op == seq_pkg::OP_LOOP) || (op == seq_pkg::OP_ILOOP);
    at_end = !halt && !start && (op == seq_pkg::OP_CONTINUE || inc == m_loop.ending);
    leave  = !halt && !start && (op == seq_pkg::OP_BREAK ||
             (!m_loop.infinite && at_end && m_loop.index + 16'd1 == m_loop.total));
    if (halt)
      nxt = m_pc;
    else if (op == seq_pkg::OP_RETURN)
      nxt = (m_calls.size() > 0) ? m_calls[0] : '0;
    else if (op == seq_pkg::OP_JUMPI || op == seq_pkg::OP_CALLI)
      nxt = imm[7:0];
    else if (leave)
      nxt = m_loop.ending;
    else if (at_end)
      nxt = m_loop.beginning;
    else
      nxt = inc;
    if (op == seq_pkg::OP_CALLI) begin
      m_calls.push_front(inc);
      if (m_calls.size() > CSTACK_DEPTH) void'(m_calls.pop_back());
    end else if (op == seq_pkg::OP_RETURN && m_calls.size() > 0) begin
      void'(m_calls.pop_front());
    end
    if (start) begin
      m_loops.push_front(m_loop);
      if (m_loops.size() > LSTACK_DEPTH) void'(m_loops.pop_back());
      m_loop.beginning = inc;
      m_loop.ending    = imm[7:0];
      m_loop.infinite  = (op == seq_pkg::OP_ILOOP);
      m_loop.total     = (op == seq_pkg::OP_LOOP) ? seq_pkg::word_t'(imm[15:8]) : '0;
      m_loop.index     = '0;
    end else if (leave) begin
      m_loop = (m_loops.size() > 0) ? m_loops.pop_front() : reset_loop();
    end else if (at_end) begin
      m_loop.index = m_loop.index + 16'd1;
    end
    m_pc = nxt;
  endtask

  // Outputs are compared half a cycle after the edge, once they have settled
  always @(negedge clk) begin
    if (rst) begin
      model_reset();
    end else if (checking) begin
      exp_index = m_loop.index;
      model_cycle(exp_addr);
      checks++;
      addr_matches: assert (programmem_addr === exp_addr) else begin
        $display("[FAIL] programmem_addr expected %h actual %h", exp_addr, programmem_addr);
        errors++;
      end
      index_matches: assert (loop_index === exp_index) else begin
        $display("[FAIL] loop_index expected %h actual %h", exp_index, loop_index);
        errors++;
      end
    end
  end

  task automatic load_filler();
    @(posedge clk);
    @(negedge clk);
    for (int i = 0; i < 256; i++) begin
      mem[i] = filler_word();
    end
  endtask

  task automatic run_test(input string name, input int cycles);
    int errs_before;
    errs_before = total_errors();
    @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    checking = 1'b1;
    repeat (cycles) @(posedge clk);
    checking = 1'b0;
    tests++;
    if (total_errors() != errs_before) failed++;
    $display("%-16s %s, %0d errors", name,
             (total_errors() == errs_before) ? "ok" : "failed", total_errors() - errs_before);
  endtask

  initial begin
    void'($urandom(32'hf3b8a9ed));
    rst = 1'b1;
    programmem_read_value = '0;
    checking = 1'b0;
    checks = 0;
    errors = 0;
    tests = 0;
    failed = 0;

    load_filler();
    run_test("sequential_wrap", 262);

    load_filler();
    mem[1]  = encode(seq_pkg::OP_JUMPI, 16'd10);
    mem[12] = encode(seq_pkg::OP_HALT, 16'd0);
    run_test("jump_halt", 16);

    // Four nested calls where each callee returns right away
    load_filler();
    mem[0]  = encode(seq_pkg::OP_CALLI, 16'd20);
    mem[20] = encode(seq_pkg::OP_CALLI, 16'd30);
    mem[30] = encode(seq_pkg::OP_CALLI, 16'd40);
    mem[40] = encode(seq_pkg::OP_CALLI, 16'd50);
    mem[50] = encode(seq_pkg::OP_RETURN, 16'd0);
    mem[41] = encode(seq_pkg::OP_RETURN, 16'd0);
    mem[31] = encode(seq_pkg::OP_RETURN, 16'd0);
    mem[21] = encode(seq_pkg::OP_RETURN, 16'd0);
    mem[2]  = encode(seq_pkg::OP_HALT, 16'd0);
    run_test("nested_calls", 18);

    // Body 1..3 runs three times, then execution goes on at 4
    load_filler();
    mem[0] = encode(seq_pkg::OP_LOOP, {8'd3, 8'd4});
    mem[5] = encode(seq_pkg::OP_HALT, 16'd0);
    run_test("counted_loop", 18);

    // The jump at 2 also closes one outer iteration, so the outer index is 1
    load_filler();
    mem[0]  = encode(seq_pkg::OP_ILOOP, 16'd3);
    mem[2]  = encode(seq_pkg::OP_JUMPI, 16'd10);
    mem[10] = encode(seq_pkg::OP_LOOP, {8'd2, 8'd14});
    mem[12] = encode(seq_pkg::OP_CONTINUE, 16'd0);
    mem[14] = encode(seq_pkg::OP_ILOOP, 16'd20);
    mem[16] = encode(seq_pkg::OP_BREAK, 16'd0);
    mem[20] = encode(seq_pkg::OP_HALT, 16'd0);
    run_test("break_continue", 18);

    $display("%0d tests, %0d failed, %0d cycles checked, %0d errors",
             tests, failed, checks, total_errors());
    if (failed == 0 && total_errors() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== tests/flow_core_props.sv ====
`timescale 1ns/1ps

module flow_core_props (
  input logic                clk,
  input logic                rst,
  input seq_pkg::prog_addr_t programmem_addr,
  input seq_pkg::instr_t     programmem_read_value
);

  // Assertion failures seen so far
  int fail_count = 0;

  logic halt_fetched;

  assign halt_fetched =
    programmem_read_value[seq_pkg::OPCODE_LSB +: seq_pkg::OPCODE_W] == seq_pkg::OP_HALT;

  // The fetch address is pinned at zero for the whole reset
  reset_addr_zero: assert property (@(posedge clk) rst |-> programmem_addr == '0)
    else begin
      $error("fetch address is not zero while reset is high");
      fail_count++;
    end

  // A halted core keeps fetching the same address
  halt_holds_addr: assert property (
    @(posedge clk) disable iff (rst) halt_fetched |=> $stable(programmem_addr)
  ) else begin
    $error("fetch address moved after a halt was fetched");
    fail_count++;
  end

endmodule

bind flow_core flow_core_props u_props (
  .clk                   (clk),
  .rst                   (rst),
  .programmem_addr       (programmem_addr),
  .programmem_read_value (programmem_read_value)
);

// ==== design/flow_core.sv ====
`timescale 1ns/1ps

module flow_core #(
  parameter int CSTACK_DEPTH = 4,
  parameter int LSTACK_DEPTH = 3
) (
  input  logic                clk,
  input  logic                rst,
  output seq_pkg::prog_addr_t programmem_addr,
  input  seq_pkg::instr_t     programmem_read_value,
  output seq_pkg::word_t      loop_index
);

  call_if cs_bus ();
  loop_if lp_bus ();

  call_stack #(
    .CSTACK_DEPTH(CSTACK_DEPTH)
  ) u_call_stack (
    .clk (clk),
    .rst (rst),
    .cs  (cs_bus.stack)
  );

  loop_unit #(
    .LSTACK_DEPTH(LSTACK_DEPTH)
  ) u_loop_unit (
    .clk (clk),
    .rst (rst),
    .lp  (lp_bus.loop)
  );

  // The fetched word always belongs to the current PC
  pc_sequencer u_pc_sequencer (
    .clk       (clk),
    .rst       (rst),
    .instr     (programmem_read_value),
    .next_addr (programmem_addr),
    .cs        (cs_bus.seq),
    .lp        (lp_bus.seq)
  );

  assign loop_index = lp_bus.index;

endmodule

// ==== design/pc_sequencer.sv ====
`timescale 1ns/1ps

module pc_sequencer (
  input  logic                clk,
  input  logic                rst,
  input  seq_pkg::instr_t     instr,
  output seq_pkg::prog_addr_t next_addr,
  call_if.seq                 cs,
  loop_if.seq                 lp
);

  seq_pkg::prog_addr_t pc;
  seq_pkg::prog_addr_t pc_advance;
  seq_pkg::word_t      imm;
  seq_pkg::prog_addr_t imm_addr;
  logic [seq_pkg::OPCODE_W-1:0] opcode;

  logic is_jump;
  logic is_call;
  logic is_return;
  logic is_loop;
  logic is_iloop;
  logic is_break;
  logic is_continue;
  logic is_halt;

  assign opcode     = instr[seq_pkg::OPCODE_LSB +: seq_pkg::OPCODE_W];
  assign imm        = instr[seq_pkg::IMM_LSB +: seq_pkg::WORD_W];
  assign imm_addr   = imm[seq_pkg::LOOP_ADDR_LSB +: seq_pkg::PROG_ADDR_W];
  assign pc_advance = pc + seq_pkg::prog_addr_t'(1);

  // Undefined opcodes leave every flag low and behave as OP_NOP
  always_comb begin
    is_jump     = 1'b0;
    is_call     = 1'b0;
    is_return   = 1'b0;
    is_loop     = 1'b0;
    is_iloop    = 1'b0;
    is_break    = 1'b0;
    is_continue = 1'b0;
    is_halt     = 1'b0;
    case (opcode)
      seq_pkg::OP_JUMPI:    is_jump = 1'b1;
      seq_pkg::OP_CALLI:    is_call = 1'b1;
      seq_pkg::OP_RETURN:   is_return = 1'b1;
      seq_pkg::OP_LOOP:     is_loop = 1'b1;
      seq_pkg::OP_ILOOP:    is_iloop = 1'b1;
      seq_pkg::OP_BREAK:    is_break = 1'b1;
      seq_pkg::OP_CONTINUE: is_continue = 1'b1;
      seq_pkg::OP_HALT:     is_halt = 1'b1;
      default: ;
    endcase
  end

  // A call saves the address of the instruction that follows it
  assign cs.push      = is_call;
  assign cs.pop       = is_return;
  assign cs.push_addr = pc_advance;

  assign lp.step           = !is_halt;
  assign lp.start          = is_loop || is_iloop;
  assign lp.start_infinite = is_iloop;
  assign lp.start_ending   = imm_addr;
  assign lp.start_total    = is_loop ?
      seq_pkg::word_t'(imm[seq_pkg::LOOP_TOTAL_LSB +: seq_pkg::LOOP_TOTAL_W]) : '0;
  assign lp.brk            = is_break;
  assign lp.cont           = is_continue;
  assign lp.pc_advance     = pc_advance;

  // Next fetch address, highest priority first
  assign next_addr = rst                 ? '0 :
                     is_halt             ? pc :
                     is_return           ? cs.top_addr :
                     (is_jump || is_call) ? imm_addr :
                     lp.redirect_end     ? lp.ending :
                     lp.redirect_begin   ? lp.beginning :
                     pc_advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= next_addr;
    end
  end

endmodule

// ==== design/loop_unit.sv ====
`timescale 1ns/1ps

module loop_unit #(
  parameter int LSTACK_DEPTH = 3
) (
  input logic clk,
  input logic rst,
  loop_if.loop lp
);

  // A saved loop holds beginning, ending, infinite flag, total and index
  localparam int ENTRY_W = 2 * seq_pkg::PROG_ADDR_W + 1 + 2 * seq_pkg::WORD_W;

  // The reset loop spans the whole program and never ends
  localparam logic [ENTRY_W-1:0] RESET_ENTRY = {
    seq_pkg::prog_addr_t'(0),
    seq_pkg::prog_addr_t'(0),
    1'b1,
    seq_pkg::word_t'(0),
    seq_pkg::word_t'(0)
  };

  seq_pkg::prog_addr_t beginning;
  seq_pkg::prog_addr_t ending;
  logic                infinite;
  seq_pkg::word_t      total;
  seq_pkg::word_t      index;

  seq_pkg::word_t      index_advance;
  logic                loop_event;
  logic                loop_done;
  logic [ENTRY_W-1:0]  active_entry;

  // Enclosing loops, entry 0 is the innermost one
  logic [ENTRY_W-1:0]  stack_q [LSTACK_DEPTH];

  assign index_advance = index + seq_pkg::word_t'(1);
  assign active_entry  = {beginning, ending, infinite, total, index};

  // A loop end is reached by running into the ending address or by a continue
  assign loop_event = lp.step && !lp.start && (lp.cont || lp.pc_advance == ending);

  // Counted loops finish on the event where the next index would hit the total
  assign loop_done = lp.step && !lp.start &&
                     (lp.brk || (!infinite && loop_event && index_advance == total));

  assign lp.redirect_end   = loop_done;
  assign lp.redirect_begin = loop_event && !loop_done;
  assign lp.beginning      = beginning;
  assign lp.ending         = ending;
  assign lp.index          = index;

  always_ff @(posedge clk) begin
    if (rst) begin
      {beginning, ending, infinite, total, index} <= RESET_ENTRY;
      for (int i = 0; i < LSTACK_DEPTH; i++) begin
        stack_q[i] <= RESET_ENTRY;
      end
    end else if (lp.start) begin
      // Save the active loop and open the new one just after the loop instruction
      stack_q[0] <= active_entry;
      for (int i = 1; i < LSTACK_DEPTH; i++) begin
        stack_q[i] <= stack_q[i-1];
      end
      beginning <= lp.pc_advance;
      ending    <= lp.start_ending;
      infinite  <= lp.start_infinite;
      total     <= lp.start_total;
      index     <= '0;
    end else if (loop_done) begin
      {beginning, ending, infinite, total, index} <= stack_q[0];
      for (int i = 0; i < LSTACK_DEPTH - 1; i++) begin
        stack_q[i] <= stack_q[i+1];
      end
      // An exhausted stack falls back to the reset loop
      stack_q[LSTACK_DEPTH-1] <= RESET_ENTRY;
    end else if (loop_event) begin
      index <= index_advance;
    end
  end

endmodule

// ==== design/call_stack.sv ====
`timescale 1ns/1ps

module call_stack #(
  parameter int CSTACK_DEPTH = 4
) (
  input logic clk,
  input logic rst,
  call_if.stack cs
);

  // Entry 0 is the most recent return address
  seq_pkg::prog_addr_t entries [CSTACK_DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < CSTACK_DEPTH; i++) begin
        entries[i] <= '0;
      end
    end else if (cs.push) begin
      // The oldest entry falls off the bottom when the stack is full
      entries[0] <= cs.push_addr;
      for (int i = 1; i < CSTACK_DEPTH; i++) begin
        entries[i] <= entries[i-1];
      end
    end else if (cs.pop) begin
      for (int i = 0; i < CSTACK_DEPTH - 1; i++) begin
        entries[i] <= entries[i+1];
      end
      // Popping past the bottom returns to address 0
      entries[CSTACK_DEPTH-1] <= '0;
    end
  end

  assign cs.top_addr = entries[0];

endmodule

// ==== design/seq_ifs.sv ====
`timescale 1ns/1ps

// Push and pop requests toward the return address stack
interface call_if;
  logic                push;
  logic                pop;
  seq_pkg::prog_addr_t push_addr;
  seq_pkg::prog_addr_t top_addr;

  modport seq (output push, output pop, output push_addr, input top_addr);
  modport stack (input push, input pop, input push_addr, output top_addr);
endinterface

// Loop control between the sequencer and the loop unit
interface loop_if;
  logic                step;
  logic                start;
  logic                start_infinite;
  seq_pkg::prog_addr_t start_ending;
  seq_pkg::word_t      start_total;
  logic                brk;
  logic                cont;
  seq_pkg::prog_addr_t pc_advance;

  logic                redirect_end;
  logic                redirect_begin;
  seq_pkg::prog_addr_t beginning;
  seq_pkg::prog_addr_t ending;
  seq_pkg::word_t      index;

  modport seq (
    output step, output start, output start_infinite, output start_ending,
    output start_total, output brk, output cont, output pc_advance,
    input redirect_end, input redirect_begin, input beginning, input ending, input index
  );
  modport loop (
    input step, input start, input start_infinite, input start_ending,
    input start_total, input brk, input cont, input pc_advance,
    output redirect_end, output redirect_begin, output beginning, output ending,
    output index
  );
endinterface

// ==== design/seq_pkg.sv ====
package seq_pkg;

  // Datapath widths fixed by the instruction encoding
  localparam int WORD_W      = 16;
  localparam int PROG_ADDR_W = 8;
  localparam int OPCODE_W    = 8;
  localparam int INSTR_W     = WORD_W + OPCODE_W;

  // Immediate and loop count word
  typedef logic [WORD_W-1:0] word_t;

  // Program memory address
  typedef logic [PROG_ADDR_W-1:0] prog_addr_t;

  // Fetched program word, immediate above the opcode
  typedef logic [INSTR_W-1:0] instr_t;

  // Opcodes of the sequencing slice; unlisted values run as OP_NOP
  typedef enum logic [OPCODE_W-1:0] {
    OP_NOP      = 8'h00,
    OP_JUMPI    = 8'h01,
    OP_CALLI    = 8'h02,
    OP_RETURN   = 8'h03,
    OP_LOOP     = 8'h04,
    OP_ILOOP    = 8'h05,
    OP_BREAK    = 8'h06,
    OP_CONTINUE = 8'h07,
    OP_HALT     = 8'h08
  } opcode_t;

  // Position of the opcode and the immediate inside instr_t
  localparam int OPCODE_LSB = 0;
  localparam int IMM_LSB    = OPCODE_W;

  // Fields inside the immediate of OP_LOOP and OP_ILOOP
  localparam int LOOP_ADDR_LSB  = 0;
  localparam int LOOP_TOTAL_LSB = 8;
  localparam int LOOP_TOTAL_W   = 8;

endpackage
